// File: sim.f
+incdir+sim
hdl/mvuPkg.sv
hdl/weightMem.sv
hdl/mvuSequencer.sv
hdl/mvuCore.sv
hdl/resultFifo.sv
hdl/requantSerializer.sv
hdl/mvuTop.sv
sim/mvuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mvuTb -f sim.f -o mvuSim

# Simulation status is taken from the log, not from the exit code
./obj_dir/mvuSim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
	exit 0
else
	exit 1
fi

// File: sim/mvuVectors.svh
// One test per row, tile t of a vector uses wBase and aBase rotated left by t nibbles
typedef struct packed {
	logic [FOLD_WIDTH-1:0]  fold;	// Tiles per vector minus one
	logic [MAX_FOLD-1:0]    padMask;	// Bit t pads tile t of every vector
	logic [3:0]             gap;	// Idle cycles after each strobe
	logic [7:0]             vectors;	// Vectors sent for this test
	logic                   randFill;	// Random weights and activations
	logic [WTILE_WIDTH-1:0] wBase;
	logic [ATILE_WIDTH-1:0] aBase;
} testRow_t;

localparam int NUM_TESTS = 9;

string testName [NUM_TESTS] = '{
	"single", "fold8", "backToBack", "padded", "allPad",
	"clampNeg", "saturate", "rewrite", "randomBurst"
};

// Columns: fold, padMask, gap, vectors, randFill, wBase, aBase
localparam testRow_t TEST_TABLE [NUM_TESTS] = '{
	'{3'd0, 8'h00, 4'd0, 8'd1, 1'b0, 32'h4321_1234, 16'h1234},	// Small single tile
	'{3'd7, 8'h00, 4'd0, 8'd1, 1'b0, 32'h2103_41E2, 16'h3152},	// Eight tiles, mixed signs
	'{3'd7, 8'h00, 4'd0, 8'd3, 1'b0, 32'h1211_2112, 16'h2132},	// Carry-over would double
	'{3'd3, 8'h0A, 4'd2, 8'd2, 1'b0, 32'h3142_2413, 16'h4271},	// Tiles 1 and 3 padded
	'{3'd3, 8'hFF, 4'd1, 8'd1, 1'b0, 32'h7777_7777, 16'hFFFF},	// Everything padded
	'{3'd1, 8'h00, 4'd0, 8'd1, 1'b0, 32'h8888_8888, 16'hFFFF},	// Large negative sum
	'{3'd7, 8'h00, 4'd0, 8'd1, 1'b0, 32'h7777_7777, 16'hFFFF},	// Far above 255
	'{3'd0, 8'h00, 4'd1, 8'd2, 1'b0, 32'h1234_4321, 16'h1234},	// PE rows of single swapped
	'{3'd0, 8'h00, 4'd0, 8'd48, 1'b1, 32'h0000_0000, 16'h0000}	// Paced by hold only
};

// File: sim/mvuTb.sv
`timescale 1ns/1ns

module mvuTb;
	import mvuPkg::*;

	`include "mvuVectors.svh"

	localparam int TIMEOUT = 2000;	// Cycle limit of every wait loop
	localparam int DRAIN = 12;	// Quiet cycles in which no extra beat may show up

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   wWr;
	logic [FOLD_WIDTH-1:0]  wAddr;
	logic [WTILE_WIDTH-1:0] wData;
	logic [FOLD_WIDTH-1:0]  foldCount;
	logic                   aStrobe;
	logic [ATILE_WIDTH-1:0] aData;
	logic                   aPad;
	logic                   outVld;
	logic [OUT_WIDTH-1:0]   outData;
	logic [LANE_WIDTH-1:0]  outLane;
	logic                   hold;

	logic [WTILE_WIDTH-1:0] wTile [MAX_FOLD];	// Weights of the current row
	logic [ATILE_WIDTH-1:0] actQ [$];	// Tiles in strobe order
	logic                   padQ [$];
	int                     expQ [$];	// Expected beats, lane 0 first
	logic [OUT_WIDTH-1:0]   gotData [$];
	logic [LANE_WIDTH-1:0]  gotLane [$];
	int                     passCount = 0;
	int                     failCount = 0;
	bit                     timedOut = 1'b0;

	always #5 clk = ~clk;	// 10 ns period

	mvuTop mvuTop_i (.*);

	// Beat monitor on the falling edge, outputs settled by then
	always @(negedge clk) begin
		if (!rst && outVld) begin
			gotData.push_back(outData);
			gotLane.push_back(outLane);
		end
	end

	// Inputs change 1 ns after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [WTILE_WIDTH-1:0] rotNibbles(input logic [WTILE_WIDTH-1:0] x,
		input int n);
		logic [2*WTILE_WIDTH-1:0] d;
		d = {x, x} << (4 * n);	// Upper half is x rotated left
		return d[2*WTILE_WIDTH-1 -: WTILE_WIDTH];
	endfunction

	// Signed weight row times unsigned activations
	function automatic int dotPe(input logic [WTILE_WIDTH-1:0] w,
		input logic [ATILE_WIDTH-1:0] a, input int pe);
		logic signed [WEIGHT_WIDTH-1:0] wv;
		int acc;
		acc = 0;
		for (int s = 0; s < SIMD; s++) begin
			wv = w[(pe * SIMD + s) * WEIGHT_WIDTH +: WEIGHT_WIDTH];
			acc += int'(wv) * int'(a[s * ACTIVATION_WIDTH +: ACTIVATION_WIDTH]);
		end
		return acc;
	endfunction

	// ReLU, shift, then limit to 255
	function automatic int requant(input int acc);
		int v;
		v = (acc < 0) ? 0 : (acc >> OUT_SHIFT);
		return (v > 255) ? 255 : v;
	endfunction

	// Weights, tile stream and expected beats of one row
	task automatic buildRow(input int r);
		testRow_t               row;
		logic [ATILE_WIDTH-1:0] aB;
		int                     acc [PE];
		row = TEST_TABLE[r];
		aB = row.aBase;
		actQ.delete();
		padQ.delete();
		expQ.delete();
		for (int t = 0; t < MAX_FOLD; t++)
			wTile[t] = row.randFill ? $urandom() : rotNibbles(row.wBase, t);
		for (int v = 0; v < int'(row.vectors); v++) begin
			for (int pe = 0; pe < PE; pe++)
				acc[pe] = 0;
			for (int t = 0; t <= int'(row.fold); t++) begin
				if (row.randFill)
					actQ.push_back(ATILE_WIDTH'($urandom()));
				else
					actQ.push_back(ATILE_WIDTH'(rotNibbles({aB, aB}, t)));
				padQ.push_back(row.padMask[t]);
				for (int pe = 0; pe < PE; pe++)
					acc[pe] += padQ[$] ? 0 : dotPe(wTile[t], actQ[$], pe);	// Pads add nothing
			end
			for (int pe = 0; pe < PE; pe++)
				expQ.push_back(requant(acc[pe]));
		end
	endtask

	// Fold counter sits at 0 between tests, so every address is free to write
	task automatic loadWeights();
		for (int t = 0; t < MAX_FOLD; t++) begin
			wWr = 1'b1;
			wAddr = FOLD_WIDTH'(t);
			wData = wTile[t];
			nextCycle();
		end
		wWr = 1'b0;
	endtask

	task automatic streamTiles(input int gap);
		int n;
		for (int k = 0; k < actQ.size(); k++) begin
			n = 0;
			while (hold && n < TIMEOUT) begin	// Source pauses on hold
				nextCycle();
				n++;
			end
			if (hold) begin
				$display("Timeout: hold stayed high for %0d cycles", TIMEOUT);
				timedOut = 1'b1;
				return;
			end
			aStrobe = 1'b1;
			aData = actQ[k];
			aPad = padQ[k];
			nextCycle();
			aStrobe = 1'b0;
			aPad = 1'b0;
			repeat (gap) nextCycle();
		end
	endtask

	task automatic waitBeats(input int target, input string name);
		int n;
		n = 0;
		while (gotData.size() < target && n < TIMEOUT) begin
			nextCycle();
			n++;
		end
		if (gotData.size() < target) begin
			$display("Timeout: %s got %0d output beats of %0d", name, gotData.size(), target);
			timedOut = 1'b1;
		end
	endtask

	task automatic checkRow(input string name, input int base);
		int errs;
		errs = 0;
		if (gotData.size() != base + expQ.size()) begin	// Lost or duplicated beats
			$display("FAILED %s beat count: expected %0d, actual %0d",
				name, expQ.size(), gotData.size() - base);
			errs++;
		end
		for (int i = 0; i < expQ.size(); i++) begin
			if (gotLane[base + i] !== LANE_WIDTH'(i % PE)) begin
				$display("FAILED %s lane of beat %0d: expected %0d, actual %0d",
					name, i, i % PE, gotLane[base + i]);
				errs++;
			end
			if (gotData[base + i] !== OUT_WIDTH'(expQ[i])) begin
				$display("FAILED %s beat %0d: expected %0d, actual %0d",
					name, i, expQ[i], gotData[base + i]);
				errs++;
			end
		end
		if (errs == 0) begin
			passCount++;
			$display("%s: passed, %0d beats", name, expQ.size());
		end else begin
			failCount++;
			$display("%s: failed with %0d errors", name, errs);
		end
	endtask

	initial begin
		int base;
		void'($urandom(32'h773a));
		rst = 1'b1;
		wWr = 1'b0;
		wAddr = '0;
		wData = '0;
		foldCount = '0;
		aStrobe = 1'b0;
		aData = '0;
		aPad = 1'b0;
		repeat (2) @(posedge clk);	// Two reset cycles
		#1;
		rst = 1'b0;
		if (outVld !== 1'b0 || hold !== 1'b0) begin
			$display("FAILED reset outVld/hold: expected 0/0, actual %0d/%0d", outVld, hold);
			failCount++;
		end else begin
			passCount++;
			$display("reset: passed");
		end
		for (int r = 0; r < NUM_TESTS; r++) begin
			base = gotData.size();
			buildRow(r);
			loadWeights();
			foldCount = TEST_TABLE[r].fold;
			streamTiles(int'(TEST_TABLE[r].gap));
			if (!timedOut)
				waitBeats(base + expQ.size(), testName[r]);
			if (timedOut) begin
				failCount++;
				break;
			end
			repeat (DRAIN) nextCycle();
			checkRow(testName[r], base);
		end
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: hdl/mvuTop.sv
`timescale 1ns/1ns

module mvuTop (
	input  logic                           clk,
	input  logic                           rst,
	// Weight loading
	input  logic                           wWr,
	input  logic [mvuPkg::FOLD_WIDTH-1:0]  wAddr,
	input  logic [mvuPkg::WTILE_WIDTH-1:0] wData,
	// Configuration, stable while tiles flow
	input  logic [mvuPkg::FOLD_WIDTH-1:0]  foldCount,
	// Activation tiles
	input  logic                           aStrobe,
	input  logic [mvuPkg::ATILE_WIDTH-1:0] aData,
	input  logic                           aPad,
	// Requantized output, one lane per beat
	output logic                           outVld,
	output logic [mvuPkg::OUT_WIDTH-1:0]   outData,
	output logic [mvuPkg::LANE_WIDTH-1:0]  outLane,
	// Source must stop strobing while high
	output logic                           hold
);
	import mvuPkg::*;

	logic [FOLD_WIDTH-1:0]  rdAddr;
	logic [WTILE_WIDTH-1:0] rdData;
	logic [ATILE_WIDTH-1:0] a;
	logic                   last;
	logic                   zero;
	logic                   vld;
	logic [RES_WIDTH-1:0]   p;
	logic                   pop;
	logic [RES_WIDTH-1:0]   popData;
	logic                   empty;

	weightMem weightMem_i (
		.clk    (clk),
		.wWr    (wWr),
		.wAddr  (wAddr),
		.wData  (wData),
		.rdAddr (rdAddr),
		.rdData (rdData)
	);

	mvuSequencer mvuSequencer_i (
		.clk       (clk),
		.rst       (rst),
		.aStrobe   (aStrobe),
		.aData     (aData),
		.aPad      (aPad),
		.foldCount (foldCount),
		.rdAddr    (rdAddr),
		.a         (a),
		.last      (last),
		.zero      (zero)
	);

	// Weights come straight from the memory read register
	mvuCore mvuCore_i (
		.clk  (clk),
		.rst  (rst),
		.last (last),
		.zero (zero),
		.w    (rdData),
		.a    (a),
		.vld  (vld),
		.p    (p)
	);

	resultFifo resultFifo_i (
		.clk      (clk),
		.rst      (rst),
		.push     (vld),
		.pushData (p),
		.pop      (pop),
		.popData  (popData),
		.empty    (empty),
		.hold     (hold)
	);

	requantSerializer requantSerializer_i (
		.clk     (clk),
		.rst     (rst),
		.empty   (empty),
		.popData (popData),
		.pop     (pop),
		.outVld  (outVld),
		.outData (outData),
		.outLane (outLane)
	);

endmodule

// File: hdl/requantSerializer.sv
`timescale 1ns/1ns

module requantSerializer (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           empty,
	input  logic [mvuPkg::RES_WIDTH-1:0]   popData,
	output logic                           pop,
	output logic                           outVld,
	output logic [mvuPkg::OUT_WIDTH-1:0]   outData,
	output logic [mvuPkg::LANE_WIDTH-1:0]  outLane	// PE index of outData
);
	import mvuPkg::*;

	serState_t               state;
	logic [LANE_WIDTH-1:0]   lane;	// Lane being sent
	logic                    lastLane;
	logic signed [ACCU_WIDTH-1:0] accSel;
	logic signed [ACCU_WIDTH-1:0] shifted;
	logic [OUT_WIDTH-1:0]    quant;

	assign lastLane = (lane == LANE_WIDTH'(PE - 1));

	// Fetch on idle, or early on the final lane so vectors go back to back
	assign pop = !empty && ((state == SER_IDLE) || lastLane);

	// ReLU, arithmetic shift, clamp to OUT_MAX
	always_comb begin
		accSel = $signed(popData[lane*ACCU_WIDTH +: ACCU_WIDTH]);
		shifted = (accSel < 0) ? '0 : (accSel >>> OUT_SHIFT);
		if (shifted > $signed(ACCU_WIDTH'(OUT_MAX)))
			quant = OUT_WIDTH'(OUT_MAX);
		else
			quant = OUT_WIDTH'(shifted);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SER_IDLE;
			lane <= '0;
			outVld <= 1'b0;
		end else begin
			outVld <= (state == SER_SEND);
			case (state)
				SER_IDLE: if (pop) state <= SER_SEND;	// Data lands next cycle
				SER_SEND: begin
					if (lastLane) begin
						lane <= '0;
						state <= pop ? SER_SEND : SER_IDLE;
					end else begin
						lane <= lane + 1'b1;
					end
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

	// Lane payload
	always_ff @(posedge clk) begin
		outData <= quant;
		outLane <= lane;
	end

endmodule

// File: hdl/resultFifo.sv
`timescale 1ns/1ns

module resultFifo (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          push,	// From core vld
	input  logic [mvuPkg::RES_WIDTH-1:0]  pushData,
	input  logic                          pop,
	output logic [mvuPkg::RES_WIDTH-1:0]  popData,	// One cycle after pop
	output logic                          empty,
	output logic                          hold	// Tells the source to pause
);
	import mvuPkg::*;

	logic [RES_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [CNT_WIDTH-1:0] occ;	// Entries held
	logic                 full;

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			occ <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;	// Wraps at FIFO_DEPTH
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;	// Both or neither
			endcase
		end
	end

	// Storage and read register
	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData;
		if (pop)
			popData <= mem[rdPtr];
	end

	assign empty = (occ == '0);
	assign full = (occ == CNT_WIDTH'(FIFO_DEPTH));
	assign hold = (occ >= CNT_WIDTH'(HOLD_LEVEL));	// Early, results still in flight

	// The core cannot stall, so a push into a full buffer is lost data
	noOverflow: assert property (@(posedge clk) disable iff (rst)
		!(push && full))
		else $error("resultFifo: push while full, source ignored hold");

	noUnderflow: assert property (@(posedge clk) disable iff (rst)
		!(pop && empty))
		else $error("resultFifo: pop while empty");

endmodule

// File: hdl/mvuCore.sv
`timescale 1ns/1ns

module mvuCore (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            last,	// Final tile of a vector
	input  logic                            zero,	// Drop this tile's contribution
	input  logic [mvuPkg::WTILE_WIDTH-1:0]  w,	// PE x SIMD signed weights
	input  logic [mvuPkg::ATILE_WIDTH-1:0]  a,	// SIMD unsigned activations
	output logic                            vld,
	output logic [mvuPkg::RES_WIDTH-1:0]    p	// PE signed accumulators
);
	import mvuPkg::*;

	// Signed weight times zero-extended activation fits PROD_WIDTH
	function automatic logic signed [PROD_WIDTH-1:0] laneProd(
		input logic signed [WEIGHT_WIDTH-1:0] wv,
		input logic [ACTIVATION_WIDTH-1:0]    av
	);
		logic signed [PROD_WIDTH-1:0] wExt;
		logic signed [PROD_WIDTH-1:0] aExt;
		wExt = PROD_WIDTH'(wv);	// Sign extension
		aExt = $signed(PROD_WIDTH'(av));	// Always positive
		return wExt * aExt;
	endfunction

	logic [1:5] L;	// Last flag with one bit per stage
	logic [1:3] Z;	// Zero flag up to the accumulator

	logic [WTILE_WIDTH-1:0]         w1;
	logic [ATILE_WIDTH-1:0]         a1;
	logic signed [PROD_WIDTH-1:0]   m2 [PE][SIMD];
	logic signed [SUM_WIDTH-1:0]    sum2 [PE];	// Combinational reduction
	logic signed [SUM_WIDTH-1:0]    s3 [PE];
	logic signed [ACCU_WIDTH-1:0]   acc4 [PE];
	logic signed [ACCU_WIDTH-1:0]   res5 [PE];

	// Flag pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			L <= '0;
			Z <= '1;	// Treat startup as bubbles
		end else begin
			L <= {last, L[1:4]};
			Z <= {zero, Z[1:2]};
		end
	end
	assign vld = L[5];

	// Stage 1 input registers
	always_ff @(posedge clk) begin
		w1 <= w;
		a1 <= a;
	end

	// Stage 2 multiplies every lane on its own
	always_ff @(posedge clk) begin
		for (int pe = 0; pe < PE; pe++) begin
			for (int s = 0; s < SIMD; s++) begin
				m2[pe][s] <= laneProd(w1[(pe*SIMD + s)*WEIGHT_WIDTH +: WEIGHT_WIDTH],
					a1[s*ACTIVATION_WIDTH +: ACTIVATION_WIDTH]);
			end
		end
	end

	// Cross-SIMD reduction, one sum per PE
	always_comb begin
		for (int pe = 0; pe < PE; pe++) begin
			sum2[pe] = '0;
			for (int s = 0; s < SIMD; s++)
				sum2[pe] = sum2[pe] + SUM_WIDTH'(m2[pe][s]);	// Sign-extended
		end
	end

	// Stage 3
	always_ff @(posedge clk) begin
		s3 <= sum2;
	end

	// Stage 4 accumulates over the fold
	// L[4] still carries the previous vector's last flag while the
	// first tile of the next vector sits in stage 3
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int pe = 0; pe < PE; pe++)
				acc4[pe] <= '0;
		end else begin
			for (int pe = 0; pe < PE; pe++) begin
				acc4[pe] <= (L[4] ? '0 : acc4[pe])
					+ (Z[3] ? '0 : ACCU_WIDTH'(s3[pe]));	// Pad and bubble add 0
			end
		end
	end

	// Stage 5 result register, valid together with L[5]
	always_ff @(posedge clk) begin
		res5 <= acc4;
	end

	always_comb begin
		for (int pe = 0; pe < PE; pe++)
			p[pe*ACCU_WIDTH +: ACCU_WIDTH] = res5[pe];
	end

	// An unwritten weight word or an unmasked startup value shows up as unknown result bits
	knownResult: assert property (@(posedge clk) disable iff (rst)
		vld |-> !$isunknown(p))
		else $error("mvuCore: result with unknown bits");

endmodule

// File: hdl/mvuSequencer.sv
`timescale 1ns/1ns

module mvuSequencer (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            aStrobe,	// One activation tile
	input  logic [mvuPkg::ATILE_WIDTH-1:0]  aData,
	input  logic                            aPad,	// Tile counts but adds nothing
	input  logic [mvuPkg::FOLD_WIDTH-1:0]   foldCount,	// Tiles per vector minus one
	output logic [mvuPkg::FOLD_WIDTH-1:0]   rdAddr,
	output logic [mvuPkg::ATILE_WIDTH-1:0]  a,
	output logic                            last,
	output logic                            zero
);
	import mvuPkg::*;

	logic [FOLD_WIDTH-1:0] foldCnt;	// Position of the next tile in its vector
	logic                  atEnd;

	assign atEnd = (foldCnt == foldCount);

	// Fold counter steps on every accepted tile
	always_ff @(posedge clk) begin
		if (rst) begin
			foldCnt <= '0;
		end else if (aStrobe) begin
			if (atEnd)
				foldCnt <= '0;	// Vector complete
			else
				foldCnt <= foldCnt + 1'b1;
		end
	end

	// Weight address straight from the counter so the memory
	// registers the tile on the same edge as the activation below
	assign rdAddr = foldCnt;

	// Control flags line up with rdData
	always_ff @(posedge clk) begin
		if (rst) begin
			last <= 1'b0;
			zero <= 1'b1;	// Idle core sees bubbles
		end else begin
			last <= aStrobe && atEnd;
			zero <= !aStrobe || aPad;	// Bubble or pad tile
		end
	end

	// Activation payload
	always_ff @(posedge clk) begin
		a <= aData;
	end

	// Fold length has to stay put until the open vector is done
	foldStable: assert property (@(posedge clk) disable iff (rst)
		(foldCnt != '0) |-> $stable(foldCount))
		else $error("mvuSequencer: foldCount changed mid-vector");

endmodule

// File: hdl/weightMem.sv
`timescale 1ns/1ns

module weightMem (
	input  logic                            clk,
	input  logic                            wWr,	// External write strobe
	input  logic [mvuPkg::FOLD_WIDTH-1:0]   wAddr,
	input  logic [mvuPkg::WTILE_WIDTH-1:0]  wData,
	input  logic [mvuPkg::FOLD_WIDTH-1:0]   rdAddr,	// From the fold counter
	output logic [mvuPkg::WTILE_WIDTH-1:0]  rdData
);
	import mvuPkg::*;

	// One word holds a whole PE x SIMD weight tile
	logic [WTILE_WIDTH-1:0] mem [MAX_FOLD];

	// Write port
	always_ff @(posedge clk) begin
		if (wWr) begin
			mem[wAddr] <= wData;
		end
	end

	// Read port, data one cycle after the address
	always_ff @(posedge clk) begin
		rdData <= mem[rdAddr];
	end

	// Address 0 is also where the sequencer parks between vectors,
	// any other read address means a vector is half way through
	// and its tile must not change underneath it
	midVectorWrite: assert property (@(posedge clk)
		(wWr && (rdAddr != '0)) |-> (wAddr != rdAddr))
		else $error("weightMem: write to live tile %0d mid-vector", wAddr);

endmodule

// File: hdl/mvuPkg.sv
package mvuPkg;

	// Array shape
	localparam int unsigned PE = 2;	// Output rows per tile
	localparam int unsigned SIMD = 4;	// Activation lanes per tile

	// Element widths
	localparam int unsigned WEIGHT_WIDTH = 4;	// Signed weight
	localparam int unsigned ACTIVATION_WIDTH = 4;	// Unsigned activation
	localparam int unsigned ACCU_WIDTH = 16;	// Signed accumulator
	localparam int unsigned PROD_WIDTH = WEIGHT_WIDTH + ACTIVATION_WIDTH;
	localparam int unsigned SUM_WIDTH = PROD_WIDTH + $clog2(SIMD);	// One PE tile sum

	// Fold handling, also the weight memory depth
	localparam int unsigned MAX_FOLD = 8;
	localparam int unsigned FOLD_WIDTH = $clog2(MAX_FOLD);

	// Requantization
	localparam int unsigned OUT_WIDTH = 8;
	localparam int unsigned OUT_SHIFT = 2;
	localparam int unsigned OUT_MAX = (1 << OUT_WIDTH) - 1;	// Saturation ceiling
	localparam int unsigned LANE_WIDTH = (PE > 1) ? $clog2(PE) : 1;

	// Result buffer
	localparam int unsigned FIFO_DEPTH = 8;
	localparam int unsigned PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int unsigned CNT_WIDTH = PTR_WIDTH + 1;	// Holds 0..FIFO_DEPTH
	localparam int unsigned HOLD_LEVEL = FIFO_DEPTH - 4;	// Leaves room for the pipeline

	// Flat bus widths
	localparam int unsigned WTILE_WIDTH = PE * SIMD * WEIGHT_WIDTH;
	localparam int unsigned ATILE_WIDTH = SIMD * ACTIVATION_WIDTH;
	localparam int unsigned RES_WIDTH = PE * ACCU_WIDTH;

	// Consumer FSM
	typedef enum logic {
		SER_IDLE,	// Waiting for a vector
		SER_SEND	// Emitting PE lanes
	} serState_t;

endpackage
